/* hw/alu_pipe_pkg.sv */
package alu_pipe_pkg;

    // ----------------------------------------
    // Widths and depths
    // ----------------------------------------
    localparam int xlen         = 32;                  // Data width
    localparam int shamt_w      = $clog2(xlen);        // Shift amount bits
    localparam int result_depth = 4;                   // Queue entries, also input credits
    localparam int qptr_w       = $clog2(result_depth); // Queue pointer width
    localparam int out_credits  = 2;                   // Output credits after reset
    localparam int credit_w     = 3;                   // Credit counter width

    // RV32I major opcodes handled here
    localparam logic [6:0] opc_op     = 7'b0110011;    // Register-register
    localparam logic [6:0] opc_op_imm = 7'b0010011;    // Register-immediate

    // ----------------------------------------
    // ALU operations
    // ----------------------------------------
    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_slt,                                       // Signed less-than
        alu_sltu,                                      // Unsigned less-than
        alu_sll,
        alu_srl,
        alu_sra
    } alu_op_e;

    // ----------------------------------------
    // Channel payloads
    // ----------------------------------------
    typedef struct packed {
        logic [31:0]     instr;                        // Raw instruction word
        logic [xlen-1:0] rs1_val;
        logic [xlen-1:0] rs2_val;
    } alu_req_t;

    typedef struct packed {
        alu_op_e         op;
        logic [xlen-1:0] a;                            // Always rs1
        logic [xlen-1:0] b;                            // rs2, immediate or shamt
        logic [4:0]      rd;
        logic            illegal;
    } dec_op_t;

    typedef struct packed {
        logic [4:0]      rd;
        logic [xlen-1:0] value;                        // Zero when illegal
        logic            illegal;
    } alu_rsp_t;

endpackage

/* hw/alu_core.sv */
`timescale 1ns/1ps

module alu_core (
    input  logic [alu_pipe_pkg::xlen-1:0] a,
    input  logic [alu_pipe_pkg::xlen-1:0] b,
    input  alu_pipe_pkg::alu_op_e         op,
    output logic [alu_pipe_pkg::xlen-1:0] res
);

    // ----------------------------------------
    // Shared adder
    // ----------------------------------------
    logic                                  sub_sel;    // Subtract, also for slt
    logic [alu_pipe_pkg::xlen-1:0]         b_inv;
    logic [alu_pipe_pkg::xlen-1:0]         b_sel;
    logic [alu_pipe_pkg::xlen-1:0]         sum;
    logic                                  lt_signed;
    logic                                  lt_unsigned;
    logic [alu_pipe_pkg::shamt_w-1:0]      shamt;
    logic [2*alu_pipe_pkg::xlen-1:0]       srl_ext;
    logic [2*alu_pipe_pkg::xlen-1:0]       sra_ext;

    assign sub_sel = (op == alu_pipe_pkg::alu_sub) || (op == alu_pipe_pkg::alu_slt);
    assign b_inv   = ~b;
    assign b_sel   = sub_sel ? b_inv : b;

    // a - b as a + ~b + 1
    assign sum = a + b_sel + alu_pipe_pkg::xlen'(sub_sel);

    // ----------------------------------------
    // Compares
    // ----------------------------------------
    // Signs differ: negative a is smaller
    // Signs equal: no overflow, difference sign decides
    assign lt_signed = (a[alu_pipe_pkg::xlen-1] != b[alu_pipe_pkg::xlen-1])
                     ? a[alu_pipe_pkg::xlen-1]
                     : sum[alu_pipe_pkg::xlen-1];
    assign lt_unsigned = (a < b);

    // ----------------------------------------
    // Shifts
    // ----------------------------------------
    assign shamt = b[alu_pipe_pkg::shamt_w-1:0];       // Upper bits of b ignored

    // Shift a double-width word, fill from the upper half
    assign srl_ext = {{alu_pipe_pkg::xlen{1'b0}}, a} >> shamt;
    assign sra_ext = {{alu_pipe_pkg::xlen{a[alu_pipe_pkg::xlen-1]}}, a} >> shamt;

    // Result select
    always_comb begin
        res = '0;
        case (op)
            alu_pipe_pkg::alu_add,
            alu_pipe_pkg::alu_sub: begin
                res = sum;
            end
            alu_pipe_pkg::alu_and: begin
                res = a & b;
            end
            alu_pipe_pkg::alu_or: begin
                res = a | b;
            end
            alu_pipe_pkg::alu_xor: begin
                res = a ^ b;
            end
            alu_pipe_pkg::alu_slt: begin
                res[0] = lt_signed;                    // Upper bits stay zero
            end
            alu_pipe_pkg::alu_sltu: begin
                res[0] = lt_unsigned;
            end
            alu_pipe_pkg::alu_sll: begin
                res = a << shamt;
            end
            alu_pipe_pkg::alu_srl: begin
                res = srl_ext[alu_pipe_pkg::xlen-1:0];
            end
            alu_pipe_pkg::alu_sra: begin
                res = sra_ext[alu_pipe_pkg::xlen-1:0];
            end
            default: begin
                res = '0;
            end
        endcase
    end

endmodule

/* hw/alu_decode.sv */
`timescale 1ns/1ps

module alu_decode (
    input  logic                   clock,
    input  logic                   reset,
    input  logic                   in_valid,
    input  alu_pipe_pkg::alu_req_t in_req,
    output logic                   dec_valid,
    output alu_pipe_pkg::dec_op_t  dec_out
);

    // ----------------------------------------
    // Instruction fields
    // ----------------------------------------
    logic [6:0]                    opcode;
    logic [2:0]                    funct3;
    logic [6:0]                    funct7;
    logic                          is_op;
    logic                          is_imm;
    logic [alu_pipe_pkg::xlen-1:0] imm_i;
    logic [alu_pipe_pkg::xlen-1:0] shamt_ext;
    logic                          bad_f7;
    alu_pipe_pkg::dec_op_t         dec_next;

    assign opcode = in_req.instr[6:0];
    assign funct3 = in_req.instr[14:12];
    assign funct7 = in_req.instr[31:25];               // Upper imm bits for OP-IMM
    assign is_op  = (opcode == alu_pipe_pkg::opc_op);
    assign is_imm = (opcode == alu_pipe_pkg::opc_op_imm);

    // I-type immediate, sign extended
    assign imm_i = {{(alu_pipe_pkg::xlen-12){in_req.instr[31]}}, in_req.instr[31:20]};
    // Immediate shifts take only the shamt field
    assign shamt_ext = {{(alu_pipe_pkg::xlen-alu_pipe_pkg::shamt_w){1'b0}},
                        in_req.instr[20 +: alu_pipe_pkg::shamt_w]};

    // Operation select and funct7 legality
    always_comb begin
        dec_next.op = alu_pipe_pkg::alu_add;
        dec_next.a  = in_req.rs1_val;
        dec_next.b  = is_imm ? imm_i : in_req.rs2_val;
        dec_next.rd = in_req.instr[11:7];
        bad_f7      = 1'b0;
        case (funct3)
            3'b000: begin
                // addi has no funct7, its top bits are immediate
                dec_next.op = (is_op && funct7[5]) ? alu_pipe_pkg::alu_sub
                                                   : alu_pipe_pkg::alu_add;
                bad_f7 = is_op && (funct7 != 7'b0000000) && (funct7 != 7'b0100000);
            end
            3'b001: begin
                dec_next.op = alu_pipe_pkg::alu_sll;
                bad_f7      = (funct7 != 7'b0000000);  // slli checked too
                if (is_imm) dec_next.b = shamt_ext;
            end
            3'b010: begin
                dec_next.op = alu_pipe_pkg::alu_slt;
                bad_f7      = is_op && (funct7 != 7'b0000000);
            end
            3'b011: begin
                dec_next.op = alu_pipe_pkg::alu_sltu;
                bad_f7      = is_op && (funct7 != 7'b0000000);
            end
            3'b100: begin
                dec_next.op = alu_pipe_pkg::alu_xor;
                bad_f7      = is_op && (funct7 != 7'b0000000);
            end
            3'b101: begin
                // Bit 30 picks arithmetic, same for srai
                dec_next.op = funct7[5] ? alu_pipe_pkg::alu_sra : alu_pipe_pkg::alu_srl;
                bad_f7      = (funct7 != 7'b0000000) && (funct7 != 7'b0100000);
                if (is_imm) dec_next.b = shamt_ext;
            end
            3'b110: begin
                dec_next.op = alu_pipe_pkg::alu_or;
                bad_f7      = is_op && (funct7 != 7'b0000000);
            end
            default: begin
                dec_next.op = alu_pipe_pkg::alu_and;
                bad_f7      = is_op && (funct7 != 7'b0000000);
            end
        endcase
        dec_next.illegal = !(is_op || is_imm) || bad_f7;
    end

    // ----------------------------------------
    // Stage register
    // ----------------------------------------
    always_ff @(posedge clock) begin
        if (reset) dec_valid <= 1'b0;
        else       dec_valid <= in_valid;              // One beat per accepted request
    end

    always_ff @(posedge clock) begin
        if (in_valid) dec_out <= dec_next;             // Payload, no reset
    end

endmodule

/* hw/alu_execute.sv */
`timescale 1ns/1ps

module alu_execute (
    input  logic                   clock,
    input  logic                   reset,
    input  logic                   dec_valid,
    input  alu_pipe_pkg::dec_op_t  dec_out,
    output logic                   ex_valid,
    output alu_pipe_pkg::alu_rsp_t ex_out
);

    logic [alu_pipe_pkg::xlen-1:0] core_res;           // Combinational ALU output

    // ----------------------------------------
    // ALU
    // ----------------------------------------
    alu_core u_core (
        .a   (dec_out.a),
        .b   (dec_out.b),
        .op  (dec_out.op),
        .res (core_res)
    );

    // ----------------------------------------
    // Stage register
    // ----------------------------------------
    always_ff @(posedge clock) begin
        if (reset) ex_valid <= 1'b0;
        else       ex_valid <= dec_valid;              // Never stalls
    end

    // rd and illegal ride along with the value
    always_ff @(posedge clock) begin
        if (dec_valid) begin
            ex_out.rd      <= dec_out.rd;
            ex_out.illegal <= dec_out.illegal;
            // Illegal encodings return zero
            ex_out.value   <= dec_out.illegal ? '0 : core_res;
        end
    end

endmodule

/* hw/alu_result.sv */
`timescale 1ns/1ps

module alu_result (
    input  logic                   clock,
    input  logic                   reset,
    input  logic                   ex_valid,
    input  alu_pipe_pkg::alu_rsp_t ex_out,
    input  logic                   out_credit,
    output logic                   out_valid,
    output alu_pipe_pkg::alu_rsp_t out_rsp,
    output logic                   in_credit
);

    // ----------------------------------------
    // Result queue
    // ----------------------------------------
    alu_pipe_pkg::alu_rsp_t              q_mem [alu_pipe_pkg::result_depth];
    logic [alu_pipe_pkg::qptr_w-1:0]     q_head;       // Oldest entry
    logic [alu_pipe_pkg::qptr_w-1:0]     q_tail;       // Next free slot
    logic [alu_pipe_pkg::qptr_w:0]       q_count;      // 0 to result_depth
    logic                                q_empty;
    logic [alu_pipe_pkg::credit_w-1:0]   credit_cnt;   // Output credits held
    logic                                push;
    logic                                pop;

    assign q_empty = (q_count == '0);
    assign push    = ex_valid;                         // Slot reserved by input credit
    // Pop whenever an entry and an output credit are both there
    assign pop     = !q_empty && (credit_cnt != '0);

    // Entry storage, no reset
    always_ff @(posedge clock) begin
        if (push) q_mem[q_tail] <= ex_out;
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            q_head <= '0;
            q_tail <= '0;
        end else begin
            if (push) q_tail <= q_tail + 1'b1;         // Wraps, depth is a power of two
            if (pop)  q_head <= q_head + 1'b1;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            q_count <= '0;
        end else begin
            case ({push, pop})
                2'b10:   q_count <= q_count + 1'b1;
                2'b01:   q_count <= q_count - 1'b1;
                default: q_count <= q_count;           // Both or neither
            endcase
        end
    end

    // ----------------------------------------
    // Output credits
    // ----------------------------------------
    always_ff @(posedge clock) begin
        if (reset) begin
            credit_cnt <= alu_pipe_pkg::credit_w'(alu_pipe_pkg::out_credits);
        end else begin
            case ({pop, out_credit})
                2'b10:   credit_cnt <= credit_cnt - 1'b1;  // Spent on a send
                2'b01:   credit_cnt <= credit_cnt + 1'b1;  // Returned by downstream
                default: credit_cnt <= credit_cnt;         // Send and return cancel
            endcase
        end
    end

    // ----------------------------------------
    // Output register and credit return
    // ----------------------------------------
    always_ff @(posedge clock) begin
        if (pop) out_rsp <= q_mem[q_head];
    end

    // in_credit lines up with out_valid, one per freed slot
    always_ff @(posedge clock) begin
        if (reset) begin
            out_valid <= 1'b0;
            in_credit <= 1'b0;
        end else begin
            out_valid <= pop;
            in_credit <= pop;
        end
    end

endmodule

/* hw/alu_pipe_top.sv */
`timescale 1ns/1ps

module alu_pipe_top (
    input  logic                   clock,
    input  logic                   reset,
    // Input channel, credit based
    input  logic                   in_valid,
    input  alu_pipe_pkg::alu_req_t in_req,
    output logic                   in_credit,
    // Output channel, credit based
    output logic                   out_valid,
    output alu_pipe_pkg::alu_rsp_t out_rsp,
    input  logic                   out_credit
);

    // ----------------------------------------
    // Internal links
    // ----------------------------------------
    logic                   dec_valid;
    alu_pipe_pkg::dec_op_t  dec_out;                   // Decode to execute
    logic                   ex_valid;
    alu_pipe_pkg::alu_rsp_t ex_out;                    // Execute to result

    // Stage 1
    alu_decode u_decode (
        .clock     (clock),
        .reset     (reset),
        .in_valid  (in_valid),
        .in_req    (in_req),
        .dec_valid (dec_valid),
        .dec_out   (dec_out)
    );

    // Stage 2
    alu_execute u_execute (
        .clock     (clock),
        .reset     (reset),
        .dec_valid (dec_valid),
        .dec_out   (dec_out),
        .ex_valid  (ex_valid),
        .ex_out    (ex_out)
    );

    // Queue and both credit loops
    alu_result u_result (
        .clock      (clock),
        .reset      (reset),
        .ex_valid   (ex_valid),
        .ex_out     (ex_out),
        .out_credit (out_credit),
        .out_valid  (out_valid),
        .out_rsp    (out_rsp),
        .in_credit  (in_credit)
    );

endmodule

/* verification/alu_pipe_sva.sv */
`timescale 1ns/1ps

module alu_pipe_sva (
    input logic                              clock,
    input logic                              reset,
    input logic                              push,
    input logic                              out_valid,
    input logic                              out_credit,
    input logic                              in_credit,
    input logic [alu_pipe_pkg::credit_w-1:0] credit_cnt,
    input logic [alu_pipe_pkg::qptr_w:0]     q_count
);

    // Responses on the wire not yet credited back
    logic [alu_pipe_pkg::credit_w-1:0] in_flight;

    always_ff @(posedge clock) begin
        if (reset) in_flight <= '0;
        else       in_flight <= in_flight + out_valid - out_credit;
    end

    // ----------------------------------------
    // Output credits
    // ----------------------------------------
    a_credit_max: assert property (@(posedge clock) disable iff (reset)
        credit_cnt <= alu_pipe_pkg::out_credits)
        else $error("output credit counter above its reset value");

    // Sends never run ahead of returned credits
    a_send_credit: assert property (@(posedge clock) disable iff (reset)
        in_flight <= alu_pipe_pkg::out_credits)
        else $error("out_valid with no output credit held");

    // ----------------------------------------
    // Queue and reset
    // ----------------------------------------
    a_no_overflow: assert property (@(posedge clock) disable iff (reset)
        push |-> q_count < alu_pipe_pkg::result_depth)
        else $error("push into a full result queue");

    a_reset_quiet: assert property (@(posedge clock)
        reset |=> !out_valid && !in_credit)
        else $error("out_valid or in_credit high after a reset cycle");

endmodule

bind alu_result alu_pipe_sva u_sva (
    .clock      (clock),
    .reset      (reset),
    .push       (push),
    .out_valid  (out_valid),
    .out_credit (out_credit),
    .in_credit  (in_credit),
    .credit_cnt (credit_cnt),
    .q_count    (q_count)
);

/* verification/alu_pipe_tb.sv */
`timescale 1ns/1ps

module alu_pipe_tb;

    logic                   clock = 1'b0;
    logic                   reset;
    logic                   in_valid;
    alu_pipe_pkg::alu_req_t in_req;
    logic                   in_credit;
    logic                   out_valid;
    alu_pipe_pkg::alu_rsp_t out_rsp;
    logic                   out_credit;

    // ----------------------------------------
    // Scoreboard state
    // ----------------------------------------
    alu_pipe_pkg::alu_req_t req_q[$];                  // Stimulus in file order
    alu_pipe_pkg::alu_rsp_t exp_q[$];                  // Expected responses in the same order
    int                     credit_due[$];             // Cycle each out credit goes back
    int num_tests;
    int sent;                                          // Requests driven
    int returned;                                      // in_credit pulses seen
    int rsp_count;                                     // Responses seen
    int out_returned;                                  // out_credit pulses driven
    int passed;
    int failed;
    int error_count;
    int cycles;                                        // Falling edges since start
    int limit;

    alu_pipe_top UUT (
        .clock      (clock),
        .reset      (reset),
        .in_valid   (in_valid),
        .in_req     (in_req),
        .in_credit  (in_credit),
        .out_valid  (out_valid),
        .out_rsp    (out_rsp),
        .out_credit (out_credit)
    );

    always #2 clock = ~clock;                          // 4 ns period

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            $display("mismatch at %0t: %s got %h, expected %h", $time, name, got, expected);
            error_count++;
        end
    endtask

    // ----------------------------------------
    // Monitor and driver on the falling edge
    // ----------------------------------------
    always @(negedge clock) begin : drive_and_monitor
        int                     errs_before;
        int                     due_idx;
        alu_pipe_pkg::alu_rsp_t exp_rsp;
        cycles++;
        if (cycles >= 5) begin
            reset = 1'b0;                              // Five rising edges in reset
            if (in_credit) returned++;
            if (returned > sent) begin
                $display("in_credit pulsed at %0t with no request outstanding", $time);
                error_count++;
            end
            if (out_valid) begin
                if (rsp_count >= num_tests) begin
                    $display("Response at %0t after all tests were answered", $time);
                    error_count++;
                end else begin
                    exp_rsp     = exp_q[rsp_count];
                    errs_before = error_count;
                    check_value("out_rsp.rd", out_rsp.rd, exp_rsp.rd);
                    check_value("out_rsp.illegal", out_rsp.illegal, exp_rsp.illegal);
                    check_value("out_rsp.value", out_rsp.value, exp_rsp.value);
                    if (error_count == errs_before) begin
                        passed++;
                        $display("test %0d instr %h ok", rsp_count, req_q[rsp_count].instr);
                    end else begin
                        failed++;
                        $display("test %0d instr %h failed", rsp_count,
                                 req_q[rsp_count].instr);
                    end
                end
                // Credits driven before now are already in the DUT counter
                if (rsp_count - out_returned >= alu_pipe_pkg::out_credits) begin
                    $display("Response sent at %0t without an output credit", $time);
                    error_count++;
                end
                rsp_count++;
                credit_due.push_back(cycles + $urandom_range(7, 0));
            end

            // One output credit per cycle with the oldest due first
            out_credit = 1'b0;
            due_idx    = -1;
            foreach (credit_due[i])
                if (due_idx < 0 && credit_due[i] <= cycles) due_idx = i;
            if (due_idx >= 0) begin
                credit_due.delete(due_idx);
                out_credit = 1'b1;
                out_returned++;
            end

            // Send while an input credit is held
            if (sent < num_tests && sent - returned < alu_pipe_pkg::result_depth) begin
                in_valid = 1'b1;
                in_req   = req_q[sent];
                sent++;
            end else begin
                in_valid = 1'b0;
            end
        end
    end

    // ----------------------------------------
    // Setup, pattern load and end of run
    // ----------------------------------------
    initial begin
        int                     fd;
        int                     code;
        string                  line;
        logic [31:0]            f_instr, f_rs1, f_rs2, f_rd, f_ill, f_val;
        alu_pipe_pkg::alu_req_t req;
        alu_pipe_pkg::alu_rsp_t rsp;
        void'($urandom(32'h2f9d004f));
        reset        = 1'b1;
        in_valid     = 1'b0;
        in_req       = '0;
        out_credit   = 1'b0;
        sent         = 0;
        returned     = 0;
        rsp_count    = 0;
        out_returned = 0;
        passed       = 0;
        failed       = 0;
        error_count  = 0;
        cycles       = 0;

        fd = $fopen("verification/alu_pipe_patterns.txt", "r");
        if (fd == 0) begin
            $display("Could not open the pattern file");
            error_count++;
        end else begin
            while (!$feof(fd)) begin
                line = "";
                code = $fgets(line, fd);
                // Comment lines do not scan as six fields
                if (code != 0 && $sscanf(line, "%h %h %h %h %h %h",
                                         f_instr, f_rs1, f_rs2, f_rd, f_ill, f_val) == 6) begin
                    req.instr   = f_instr;
                    req.rs1_val = f_rs1;
                    req.rs2_val = f_rs2;
                    rsp.rd      = f_rd[4:0];
                    rsp.illegal = f_ill[0];
                    rsp.value   = f_val;
                    req_q.push_back(req);
                    exp_q.push_back(rsp);
                end
            end
            $fclose(fd);
            if (req_q.size() == 0) begin
                $display("The pattern file holds no tests");
                error_count++;
            end
        end
        num_tests = req_q.size();
        limit     = 12 * num_tests + 100;

        while (rsp_count < num_tests && cycles < limit) @(posedge clock);
        if (rsp_count < num_tests) begin
            $display("Timeout after %0d cycles, %0d of %0d responses missing",
                     cycles, num_tests - rsp_count, num_tests);
            error_count++;
        end else begin
            repeat (10) @(posedge clock);              // Catch stray responses
            check_value("in_credit count", returned, rsp_count);
        end
        $display("tests %0d, passed %0d, failed %0d, errors %0d",
                 num_tests, passed, failed, error_count);
        if (error_count == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

/* alu_pipe.f */
hw/alu_pipe_pkg.sv
hw/alu_core.sv
hw/alu_decode.sv
hw/alu_execute.sv
hw/alu_result.sv
hw/alu_pipe_top.sv
verification/alu_pipe_sva.sv
verification/alu_pipe_tb.sv

/* verification/alu_pipe_patterns.txt */
// instr rs1 rs2 rd illegal value, all hex
// rd, illegal and value are the expected response
002081b3 00000005 00000007 03 0 0000000c
00208233 ffffffff 00000002 04 0 00000001
402082b3 0000000a 00000003 05 0 00000007
40208333 00000000 00000001 06 0 ffffffff
0020f3b3 f0f0ff00 0ff0f0f0 07 0 00f0f000
0020e433 f0f0ff00 0ff0f0f0 08 0 fff0fff0
0020c4b3 f0f0ff00 0ff0f0f0 09 0 ff000ff0
0020a533 ffffffff 00000001 0a 0 00000001
0020b5b3 ffffffff 00000001 0b 0 00000000
0020a533 00000001 ffffffff 0a 0 00000000
0020b5b3 00000001 ffffffff 0b 0 00000001
0020a533 fffffff0 fffffffe 0a 0 00000001
0020a533 7fffffff 80000000 0a 0 00000000
0010a613 ffffffff 00000000 0c 0 00000001
fff0a613 00000001 00000000 0c 0 00000000
fff0b693 00000001 00000000 0d 0 00000001
0010b693 ffffffff 00000000 0d 0 00000000
ffb08713 00000003 00000000 0e 0 fffffffe
0ff0f793 12345678 00000000 0f 0 00000078
8000e813 00000012 00000000 10 0 fffff812
fff0c893 0000ffff 00000000 11 0 ffff0000
00209933 80000001 00000000 12 0 80000001
00209933 80000001 00000001 12 0 00000002
00209933 00000001 0000001f 12 0 80000000
00209933 00000003 00000021 12 0 00000006
0020d9b3 80000000 00000001 13 0 40000000
0020d9b3 80000000 0000001f 13 0 00000001
0020d9b3 80000000 00000000 13 0 80000000
4020da33 80000000 00000001 14 0 c0000000
4020da33 80000000 0000001f 14 0 ffffffff
4020da33 80000000 00000000 14 0 80000000
4020da33 f0000000 ffffffe1 14 0 f8000000
00009a93 12345678 00000000 15 0 12345678
00109a93 40000001 00000000 15 0 80000002
01f09a93 00000001 00000000 15 0 80000000
0010db13 80000000 00000000 16 0 40000000
01f0db13 ffffffff 00000000 16 0 00000001
41f0db93 80000000 00000000 17 0 ffffffff
4000db93 80000010 00000000 17 0 80000010
00208c03 00000005 00000007 18 1 00000000
02208cb3 00000005 00000007 19 1 00000000
4020cd33 00000005 00000007 1a 1 00000000
40109d93 00000005 00000000 1b 1 00000000
0210de13 80000000 00000000 1c 1 00000000
12345eb7 00000005 00000007 1d 1 00000000
